// ==== hdl/dataEnginePkg.sv ====
`default_nettype none

package dataEnginePkg;

   localparam int dataW   = 32;
   localparam int daddrW  = 11;
   localparam int periodW = 6;
   // bus words: 0 port A, 1 port B, 2 adder sum
   localparam int busN    = 3;
   localparam int selW    = 2;

   // address display on outputs, no input on selection
   localparam logic [selW-1:0] selAddr = selW'(3);

   typedef struct packed {
      logic [daddrW-1:0]  iterations;
      logic [periodW-1:0] period;
      logic [periodW-1:0] duty;
      logic [selW-1:0]    sel;
      logic [daddrW-1:0]  start;
      logic [daddrW-1:0]  shift;
      logic [daddrW-1:0]  incr;
      logic [periodW-1:0] delay;
      logic               reverse;
   } memPortCfg_t;

   typedef struct packed {
      logic [selW-1:0] selA;
      logic [selW-1:0] selB;
   } adderCfg_t;

   typedef logic [dataW-1:0] dataBus_t [busN];

   // bus word picked by a selector, zero when nothing matches
   function automatic logic [dataW-1:0] busPick(input dataBus_t bus,
                                                input logic [selW-1:0] sel);
      logic [dataW-1:0] word;
      word = '0;
      for (int k = 0; k < busN; k++) begin
         if (sel == selW'(k)) word = bus[k];
      end
      return word;
   endfunction

endpackage

`default_nettype wire

// ==== hdl/hostMemIf.sv ====
`timescale 1ns/10ps
`default_nettype none

interface hostMemIf import dataEnginePkg::*; #(
   parameter int addrW = 7
) ();

   logic             req;
   logic             rnw;
   logic [addrW-1:0] addr;
   logic [dataW-1:0] wdata;
   // held until the next port B access
   logic [dataW-1:0] rdata;

   modport host (output req, output rnw, output addr, output wdata, input rdata);

   modport mem (input req, input rnw, input addr, input wdata, output rdata);

endinterface

`default_nettype wire

// ==== hdl/addrGen.sv ====
`timescale 1ns/10ps
`default_nettype none

module addrGen import dataEnginePkg::*; #(
   parameter int addrW = 7
) (
   input  logic              clk,
   input  logic              reset,
   input  logic              init,
   input  logic              run,
   input  memPortCfg_t       cfg,
   output logic [daddrW-1:0] addr,
   output logic              memEn,
   output logic              done
);

   logic               armed;
   logic [periodW-1:0] delayCnt;
   logic [daddrW-1:0]  iCnt;
   logic [periodW-1:0] jCnt;
   logic [daddrW-1:0]  base;
   logic [daddrW-1:0]  addrReg;
   logic               step;
   logic               lastJ;
   logic               lastI;

   // memory index is taken from the low bits of the address
   if (addrW > daddrW) begin : gAddrCheck
      $error("addrW larger than daddrW");
   end

   assign step  = armed && (delayCnt == '0);
   assign lastJ = (jCnt == cfg.period - 1'b1);
   assign lastI = (iCnt == cfg.iterations - 1'b1);
   assign addr  = addrReg;
   assign memEn = step && (jCnt < cfg.duty);

   always_ff @(posedge clk) begin
      if (reset || init) begin
         armed    <= 1'b0;
         delayCnt <= '0;
         done     <= 1'b0;
         iCnt     <= '0;
         jCnt     <= '0;
      end else if (run && !armed && !done && cfg.iterations != '0) begin
         armed    <= 1'b1;
         delayCnt <= cfg.delay;
      end else if (armed && delayCnt != '0) begin
         delayCnt <= delayCnt - 1'b1;
      end else if (step) begin
         if (lastJ) begin
            jCnt <= '0;
            if (lastI) begin
               armed <= 1'b0;
               done  <= 1'b1;
            end else begin
               iCnt <= iCnt + 1'b1;
            end
         end else begin
            jCnt <= jCnt + 1'b1;
         end
      end
   end

   // base moves by shift per period, address by incr inside it
   always_ff @(posedge clk) begin
      if (reset) begin
         base    <= '0;
         addrReg <= '0;
      end else if (init) begin
         base    <= cfg.start;
         addrReg <= cfg.start;
      end else if (step) begin
         if (lastJ) begin
            base    <= base + cfg.shift;
            addrReg <= base + cfg.shift;
         end else begin
            addrReg <= addrReg + cfg.incr;
         end
      end
   end

   // pattern settings must hold while the generator is active
   assert property (@(posedge clk) disable iff (reset) armed |=> $stable(cfg));

endmodule

`default_nettype wire

// ==== hdl/dataMem.sv ====
`timescale 1ns/10ps
`default_nettype none

module dataMem import dataEnginePkg::*; #(
   parameter int addrW = 7
) (
   input  logic             clk,
   input  logic             reset,
   input  logic             initA,
   input  logic             initB,
   input  logic             runA,
   input  logic             runB,
   input  memPortCfg_t      cfgA,
   input  memPortCfg_t      cfgB,
   input  dataBus_t         bus,
   hostMemIf.mem            host,
   output logic [dataW-1:0] outA,
   output logic [dataW-1:0] outB,
   output logic             doneA,
   output logic             doneB
);

   logic [dataW-1:0]  mem [2**addrW];
   logic [daddrW-1:0] genAddrA;
   logic [daddrW-1:0] genAddrB;
   logic              memEnA;
   logic              memEnB;
   logic [daddrW-1:0] portAddrA;
   logic [daddrW-1:0] portAddrB;
   logic [addrW-1:0]  memAddrA;
   logic [addrW-1:0]  memAddrB;
   logic [dataW-1:0]  wdataA;
   logic [dataW-1:0]  wdataB;
   logic              wrA;
   logic              wrB;
   logic              enB;
   logic [dataW-1:0]  rdA;
   logic [dataW-1:0]  rdB;
   logic [daddrW-1:0] shownA;
   logic [daddrW-1:0] shownB;

   function automatic logic [daddrW-1:0] reverseBits(input logic [daddrW-1:0] a);
      logic [daddrW-1:0] r;
      for (int k = 0; k < daddrW; k++) begin
         r[k] = a[daddrW-1-k];
      end
      return r;
   endfunction

   function automatic logic [dataW-1:0] showAddr(input logic [daddrW-1:0] a);
      return {{(dataW-daddrW){a[daddrW-1]}}, a};
   endfunction

   addrGen #(.addrW(addrW)) genA (
      .clk   (clk),
      .reset (reset),
      .init  (initA),
      .run   (runA),
      .cfg   (cfgA),
      .addr  (genAddrA),
      .memEn (memEnA),
      .done  (doneA)
   );

   addrGen #(.addrW(addrW)) genB (
      .clk   (clk),
      .reset (reset),
      .init  (initB),
      .run   (runB),
      .cfg   (cfgB),
      .addr  (genAddrB),
      .memEn (memEnB),
      .done  (doneB)
   );

   assign portAddrA = cfgA.reverse ? reverseBits(genAddrA) : genAddrA;
   assign portAddrB = cfgB.reverse ? reverseBits(genAddrB) : genAddrB;

   assign wrA      = memEnA && (cfgA.sel != selAddr);
   assign wdataA   = busPick(bus, cfgA.sel);
   assign memAddrA = portAddrA[addrW-1:0];

   // host request wins port B
   assign enB      = host.req || memEnB;
   assign wrB      = host.req ? !host.rnw : memEnB && (cfgB.sel != selAddr);
   assign wdataB   = host.req ? host.wdata : busPick(bus, cfgB.sel);
   assign memAddrB = host.req ? host.addr : portAddrB[addrW-1:0];

   always_ff @(posedge clk) begin
      if (wrA) mem[memAddrA] <= wdataA;
      if (wrB) mem[memAddrB] <= wdataB;
   end

   // written word passes through to the port output
   always_ff @(posedge clk) begin
      if (memEnA) rdA <= wrA ? wdataA : mem[memAddrA];
      shownA <= portAddrA;
      shownB <= portAddrB;
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         rdB <= '0;
      end else if (enB) begin
         rdB <= wrB ? wdataB : mem[memAddrB];
      end
   end

   assign host.rdata = rdB;
   assign outA       = (cfgA.sel == selAddr) ? showAddr(shownA) : rdA;
   assign outB       = (cfgB.sel == selAddr) ? showAddr(shownB) : rdB;

   // host may only touch port B while its generator is quiet
   assert property (@(posedge clk) disable iff (reset) host.req |-> !memEnB);

endmodule

`default_nettype wire

// ==== hdl/adderUnit.sv ====
`timescale 1ns/10ps
`default_nettype none

module adderUnit import dataEnginePkg::*; (
   input  logic             clk,
   input  logic             reset,
   input  adderCfg_t        cfg,
   input  dataBus_t         bus,
   output logic [dataW-1:0] sum
);

   logic [dataW-1:0] opA;
   logic [dataW-1:0] opB;

   // selAddr picks nothing, so a zero operand
   assign opA = busPick(bus, cfg.selA);
   assign opB = busPick(bus, cfg.selB);

   always_ff @(posedge clk) begin
      if (reset) begin
         sum <= '0;
      end else begin
         sum <= opA + opB;
      end
   end

endmodule

`default_nettype wire

// ==== hdl/dataEngine.sv ====
`timescale 1ns/10ps
`default_nettype none

module dataEngine import dataEnginePkg::*; #(
   parameter int addrW = 7
) (
   input  logic             clk,
   input  logic             reset,
   input  logic             initA,
   input  logic             initB,
   input  logic             runA,
   input  logic             runB,
   input  memPortCfg_t      cfgA,
   input  memPortCfg_t      cfgB,
   input  adderCfg_t        adderCfg,
   input  logic             hostReq,
   input  logic             hostRnw,
   input  logic [addrW-1:0] hostAddr,
   input  logic [dataW-1:0] hostWdata,
   output logic [dataW-1:0] hostRdata,
   output logic             doneA,
   output logic             doneB
);

   hostMemIf #(.addrW(addrW)) hostIf ();

   dataBus_t         bus;
   logic [dataW-1:0] outA;
   logic [dataW-1:0] outB;
   logic [dataW-1:0] sum;

   // host side of the port B interface
   assign hostIf.req   = hostReq;
   assign hostIf.rnw   = hostRnw;
   assign hostIf.addr  = hostAddr;
   assign hostIf.wdata = hostWdata;
   assign hostRdata    = hostIf.rdata;

   assign bus[0] = outA;
   assign bus[1] = outB;
   assign bus[2] = sum;

   dataMem #(.addrW(addrW)) dataMemUnit (
      .clk   (clk),
      .reset (reset),
      .initA (initA),
      .initB (initB),
      .runA  (runA),
      .runB  (runB),
      .cfgA  (cfgA),
      .cfgB  (cfgB),
      .bus   (bus),
      .host  (hostIf.mem),
      .outA  (outA),
      .outB  (outB),
      .doneA (doneA),
      .doneB (doneB)
   );

   adderUnit adder (
      .clk   (clk),
      .reset (reset),
      .cfg   (adderCfg),
      .bus   (bus),
      .sum   (sum)
   );

endmodule

`default_nettype wire

// ==== verif/tbClock.sv ====
`timescale 1ns/10ps
`default_nettype none

module tbClock #(
   parameter int periodNs    = 8,
   parameter int resetCycles = 3
) (
   output logic clk,
   output logic reset
);

   initial begin
      clk = 1'b0;
      forever #(periodNs / 2) clk = ~clk;
   end

   initial begin
      reset = 1'b1;
      repeat (resetCycles) @(posedge clk);
      reset <= 1'b0;
   end

endmodule

`default_nettype wire

// ==== verif/dataEngineCheck.sv ====
`timescale 1ns/10ps
`default_nettype none

module dataEngineCheck import dataEnginePkg::*; #(
   parameter int addrW = 7
) (
   input  logic             clk,
   input  logic             reset,
   input  logic             hostReq,
   input  logic             hostRnw,
   input  logic [addrW-1:0] hostAddr,
   input  logic [dataW-1:0] hostRdata,
   input  logic             initA,
   input  logic             initB,
   input  logic             doneA,
   input  logic             doneB,
   input  logic [dataW-1:0] expImage [2**addrW],
   output int               errorCount
);

   int               testCount   = 0;
   int               failedTests = 0;
   int               testErrors  = 0;
   int               readCount   = 0;
   logic             readPending = 1'b0;
   logic [addrW-1:0] readAddr    = '0;
   logic             initSeenA   = 1'b0;
   logic             initSeenB   = 1'b0;

   initial errorCount = 0;

   task automatic noteFailure(input string what);
      $display("%s", what);
      errorCount++;
      testErrors++;
   endtask

   // read data shows up the cycle after the strobe
   always @(posedge clk) begin
      if (reset) begin
         readPending <= 1'b0;
         initSeenA   <= 1'b0;
         initSeenB   <= 1'b0;
      end else begin
         if (readPending) begin
            readCount++;
            if (hostRdata !== expImage[readAddr]) begin
               $display("error hostRdata addr 0x%02h expected 0x%08h actual 0x%08h",
                        readAddr, expImage[readAddr], hostRdata);
               errorCount++;
               testErrors++;
            end
         end
         if (initSeenA && doneA) noteFailure("doneA still high the cycle after initA");
         if (initSeenB && doneB) noteFailure("doneB still high the cycle after initB");
         readPending <= hostReq && hostRnw;
         readAddr    <= hostAddr;
         initSeenA   <= initA;
         initSeenB   <= initB;
      end
   end

   task automatic expectIdle();
      if (doneA || doneB) noteFailure("done rose although iterations is zero");
   endtask

   task automatic finishTest(input string name);
      testCount++;
      if (testErrors == 0) begin
         $display("test %0d %s: ok, %0d words read", testCount, name, readCount);
      end else begin
         failedTests++;
         $display("test %0d %s: failed with %0d errors", testCount, name, testErrors);
      end
      testErrors = 0;
      readCount  = 0;
   endtask

   task automatic printSummary();
      $display("tests %0d, failed %0d, errors %0d", testCount, failedTests, errorCount);
   endtask

endmodule

`default_nettype wire

// ==== verif/dataEngineTb.sv ====
`timescale 1ns/10ps
`default_nettype none

module dataEngineTb import dataEnginePkg::*; ();

   localparam int addrW = 7;
   localparam int depth = 2**addrW;
   // steps, delays, readbacks and setup of all six tests
   localparam int stepTotal  = 16 * 4 + 40;
   localparam int delayTotal = 3 + 2 + 6 + 4;
   localparam int readTotal  = 6 * (depth + 3) + depth;
   localparam int watchdogNs = (stepTotal + delayTotal + readTotal + 40) * 8 * 2;

   logic             clk;
   logic             reset;
   logic             initA;
   logic             initB;
   logic             runA;
   logic             runB;
   memPortCfg_t      cfgA;
   memPortCfg_t      cfgB;
   adderCfg_t        adderCfg;
   logic             hostReq;
   logic             hostRnw;
   logic [addrW-1:0] hostAddr;
   logic [dataW-1:0] hostWdata;
   logic [dataW-1:0] hostRdata;
   logic             doneA;
   logic             doneB;
   logic [dataW-1:0] expImage [depth];
   logic [31:0]      lfsrState = 32'hd466dc02;
   int               failures;

   tbClock #(.periodNs(8), .resetCycles(3)) clockGen (.clk(clk), .reset(reset));

   dataEngine #(.addrW(addrW)) u_dut (
      .clk(clk), .reset(reset), .initA(initA), .initB(initB), .runA(runA), .runB(runB),
      .cfgA(cfgA), .cfgB(cfgB), .adderCfg(adderCfg), .hostReq(hostReq),
      .hostRnw(hostRnw), .hostAddr(hostAddr), .hostWdata(hostWdata),
      .hostRdata(hostRdata), .doneA(doneA), .doneB(doneB)
   );

   dataEngineCheck #(.addrW(addrW)) check (
      .clk(clk), .reset(reset), .hostReq(hostReq), .hostRnw(hostRnw),
      .hostAddr(hostAddr), .hostRdata(hostRdata), .initA(initA), .initB(initB),
      .doneA(doneA), .doneB(doneB), .expImage(expImage), .errorCount(failures)
   );

   // galois form, taps 32 22 2 1
   function automatic logic [31:0] lfsrNext(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
   endfunction

   task automatic drawWord(output logic [dataW-1:0] w);
      w = '0;
      for (int b = 0; b < dataW; b++) begin
         lfsrState = lfsrNext(lfsrState);
         w = {w[dataW-2:0], lfsrState[0]};
      end
   endtask

   function automatic memPortCfg_t portCfg(input int iter, input int period, input int duty,
         input logic [selW-1:0] sel, input int start, input int shift, input int incr,
         input int delay, input logic rev);
      memPortCfg_t c;
      c.iterations = daddrW'(iter);
      c.period     = periodW'(period);
      c.duty       = periodW'(duty);
      c.sel        = sel;
      c.start      = daddrW'(start);
      c.shift      = daddrW'(shift);
      c.incr       = daddrW'(incr);
      c.delay      = periodW'(delay);
      c.reverse    = rev;
      return c;
   endfunction

   // address of step k, start + i*shift + j*incr, reversed over daddrW when asked
   function automatic logic [daddrW-1:0] genAddr(input memPortCfg_t c, input int k);
      int                i;
      int                j;
      logic [daddrW-1:0] a;
      logic [daddrW-1:0] r;
      i = k / int'(c.period);
      j = k % int'(c.period);
      a = daddrW'(int'(c.start) + i * int'(c.shift) + j * int'(c.incr));
      r = {<<{a}};
      return c.reverse ? r : a;
   endfunction

   // port A in address mode puts its address on word 0, the adder doubles it
   function automatic logic [dataW-1:0] refWord(input logic [dataW-1:0] old,
         input logic [addrW-1:0] loc, input memPortCfg_t a, input memPortCfg_t b);
      logic [dataW-1:0]  w;
      logic [daddrW-1:0] src;
      logic [daddrW-1:0] dst;
      int                steps;
      w = old;
      steps = int'(b.iterations) * int'(b.period);
      for (int k = 0; k < steps; k++) begin
         src = genAddr(a, k);
         dst = genAddr(b, k);
         if (k % int'(b.period) < int'(b.duty) && dst[addrW-1:0] == loc) begin
            w = dataW'($signed(src)) * 2;
         end
      end
      return w;
   endfunction

   task automatic hostAccess(input logic rnw, input int k, input logic [dataW-1:0] w);
      @(posedge clk);
      hostReq   <= 1'b1;
      hostRnw   <= rnw;
      hostAddr  <= addrW'(k);
      hostWdata <= w;
   endtask

   task automatic readBack(input string name);
      for (int k = 0; k < depth; k++) begin
         hostAccess(1'b1, k, '0);
      end
      @(posedge clk);
      hostReq <= 1'b0;
      repeat (2) @(posedge clk);
      check.finishTest(name);
   endtask

   task automatic startPattern(input memPortCfg_t a, input memPortCfg_t b);
      @(posedge clk);
      cfgA  <= a;
      cfgB  <= b;
      initA <= 1'b1;
      initB <= 1'b1;
      @(posedge clk);
      initA <= 1'b0;
      initB <= 1'b0;
      runA  <= 1'b1;
      runB  <= 1'b1;
      @(posedge clk);
      runA <= 1'b0;
      runB <= 1'b0;
   endtask

   task automatic runTest(input string name, input memPortCfg_t a, input memPortCfg_t b);
      int n;
      n = 0;
      startPattern(a, b);
      while (!(doneA && doneB) && n < 100) begin
         @(posedge clk);
         n++;
      end
      if (!(doneA && doneB)) check.noteFailure("doneA and doneB did not both rise in time");
      for (int k = 0; k < depth; k++) begin
         expImage[k] = refWord(expImage[k], addrW'(k), a, b);
      end
      readBack(name);
   endtask

   initial begin
      logic [dataW-1:0] w;
      initA     <= 1'b0;
      initB     <= 1'b0;
      runA      <= 1'b0;
      runB      <= 1'b0;
      cfgA      <= '0;
      cfgB      <= '0;
      // both adder operands are word 0
      adderCfg  <= '0;
      hostReq   <= 1'b0;
      hostRnw   <= 1'b1;
      hostAddr  <= '0;
      hostWdata <= '0;
      @(posedge clk);
      while (reset) @(posedge clk);

      for (int k = 0; k < depth; k++) begin
         drawWord(w);
         expImage[k] = w;
         hostAccess(1'b0, k, w);
      end
      readBack("host write and read");

      runTest("linear loop", portCfg(1, 16, 16, selAddr, 0, 0, 1, 1, 1'b0),
              portCfg(1, 16, 16, selW'(2), 64, 0, 1, 3, 1'b0));
      runTest("two dimensional", portCfg(4, 4, 3, selAddr, 0, 8, 2, 0, 1'b0),
              portCfg(4, 4, 3, selW'(2), 32, 8, 2, 2, 1'b0));
      runTest("bit reversal", portCfg(1, 16, 16, selAddr, 0, 0, 16, 4, 1'b1),
              portCfg(1, 16, 16, selW'(2), 96, 0, 1, 6, 1'b0));

      startPattern(portCfg(0, 4, 4, selAddr, 0, 1, 1, 0, 1'b0),
                   portCfg(0, 4, 4, selW'(2), 16, 4, 1, 2, 1'b0));
      repeat (40) begin
         @(posedge clk);
         check.expectIdle();
      end
      readBack("zero iterations and done");

      runTest("second run", portCfg(2, 8, 8, selAddr, 5, 40, 3, 2, 1'b0),
              portCfg(2, 8, 6, selW'(2), 100, 8, 1, 4, 1'b0));

      check.printSummary();
      if (failures == 0) begin
         $display("TEST PASS");
      end else begin
         $display("TEST FAIL");
      end
      $finish;
   end

   initial begin
      #(watchdogNs);
      $display("watchdog expired after %0d ns, the run did not finish", watchdogNs);
      $display("TEST FAIL");
      $finish;
   end

endmodule

`default_nettype wire

// ==== verilog.f ====
hdl/dataEnginePkg.sv
hdl/hostMemIf.sv
hdl/addrGen.sv
hdl/dataMem.sv
hdl/adderUnit.sv
hdl/dataEngine.sv
verif/tbClock.sv
verif/dataEngineCheck.sv
verif/dataEngineTb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= dataEngineTb
RTL_TOP   ?= dataEngine
FILELIST  ?= verilog.f
BUILD     ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
FAIL_MSG  ?= TEST FAIL

SOURCES := $(shell cat $(FILELIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

$(BUILD)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD)

sim: $(BUILD)/V$(TOP)
	@$(BUILD)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD) $(LOG)
